//--- hw/kcpu_config.svh
// Stack RAM depth is 2**KCPU_STACK_AW bytes and only the low stack pointer bits address it
`ifndef KCPU_CONFIG_SVH
`define KCPU_CONFIG_SVH

// Register widths
`define KCPU_BYTE_W 8
`define KCPU_WORD_W 16

// Stack RAM address width, 256 bytes
`define KCPU_STACK_AW 8

`endif

//--- hw/kcpu_pkg.sv
// Register codes 6 and 7 are invalid; push/pull mask bit 7 (PC slot) is reserved and ignored
`include "kcpu_config.svh"

package kcpu_pkg;

    typedef logic [`KCPU_BYTE_W-1:0] byte_t;
    typedef logic [`KCPU_WORD_W-1:0] word_t;
    typedef logic [2:0]              reg_code_t;
    typedef logic [7:0]              stack_mask_t;
    typedef logic [1:0]              idx_sel_t;
    typedef logic [1:0]              acc_sel_t;

    // Postbyte and load select codes
    localparam reg_code_t REG_A = 3'd0;
    localparam reg_code_t REG_B = 3'd1;
    localparam reg_code_t REG_X = 3'd2;
    localparam reg_code_t REG_Y = 3'd3;
    localparam reg_code_t REG_S = 3'd4;
    localparam reg_code_t REG_U = 3'd5;

    // Bit positions in the push/pull mask
    localparam int MSK_CC    = 0;
    localparam int MSK_A     = 1;
    localparam int MSK_B     = 2;
    localparam int MSK_DP    = 3;
    localparam int MSK_X     = 4;
    localparam int MSK_Y     = 5;
    localparam int MSK_OTHER = 6;
    localparam int MSK_RSV   = 7;

    localparam idx_sel_t IDX_X = 2'd0;
    localparam idx_sel_t IDX_Y = 2'd1;
    localparam idx_sel_t IDX_U = 2'd2;
    localparam idx_sel_t IDX_S = 2'd3;

    // Any other value selects d
    localparam acc_sel_t ACC_A = 2'd0;
    localparam acc_sel_t ACC_B = 2'd1;

    typedef enum logic [2:0] {IDLE, PUSH, PULL_ADDR, PULL_LAST, DONE} seq_state_t;

endpackage

//--- hw/kcpu_regs.sv
// One strobe per cycle; loads issued during a stack operation are not arbitrated against it
`timescale 1ns/1ps
`include "kcpu_config.svh"

module kcpu_regs
    import kcpu_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        cen,
    input  logic        ld,
    input  reg_code_t   ld_sel,
    input  logic        ld_dp,
    input  word_t       ld_data,
    input  logic        tfr,
    input  logic        exg,
    input  byte_t       postbyte,
    input  logic        idx_post,
    input  logic        idx_pre,
    input  idx_sel_t    idx_sel,
    input  logic        idxw,
    input  acc_sel_t    acc_sel,
    input  stack_mask_t cur_bit,
    input  logic        hihalf,
    input  logic        sp_dec,
    input  logic        sp_inc,
    input  logic        pul_we,
    input  logic        use_u_q,
    input  byte_t       rdata,
    output word_t       sp_addr,
    output byte_t       psh_byte,
    output word_t       idx_racc,
    output byte_t       a,
    output byte_t       b,
    output byte_t       dp,
    output byte_t       cc,
    output word_t       x,
    output word_t       y,
    output word_t       u,
    output word_t       s
);

    word_t       cw_val [0:7];
    logic [7:0]  cw_en;
    reg_code_t   src_code;
    reg_code_t   dst_code;
    word_t       src_val;
    word_t       dst_val;
    logic        codes_ok;
    word_t       other_sp;
    word_t       sp_next;
    word_t       idx_step;
    word_t       d;

    // 8-bit registers read back zero-extended
    function automatic word_t read_code(reg_code_t code);
        case (code)
            REG_A:   return word_t'(a);
            REG_B:   return word_t'(b);
            REG_X:   return x;
            REG_Y:   return y;
            REG_S:   return s;
            REG_U:   return u;
            default: return '0;
        endcase
    endfunction

    function automatic byte_t get_half(word_t w, logic hi);
        return hi ? w[`KCPU_WORD_W-1:`KCPU_BYTE_W] : w[`KCPU_BYTE_W-1:0];
    endfunction

    function automatic word_t set_half(word_t w, logic hi, byte_t v);
        word_t r;
        r = w;
        if (hi)
            r[`KCPU_WORD_W-1:`KCPU_BYTE_W] = v;
        else
            r[`KCPU_BYTE_W-1:0] = v;
        return r;
    endfunction

    function automatic word_t idx_move(word_t w);
        return idx_post ? w + idx_step : w - idx_step;
    endfunction

    assign d        = {a, b};
    assign sp_addr  = use_u_q ? u : s;
    assign other_sp = use_u_q ? s : u;
    assign sp_next  = sp_dec ? sp_addr - word_t'(1) : sp_addr + word_t'(1);
    assign idx_step = idxw ? word_t'(2) : word_t'(1);

    assign src_code = postbyte[6:4];
    assign dst_code = postbyte[2:0];
    assign codes_ok = (src_code <= REG_U) && (dst_code <= REG_U);
    assign src_val  = read_code(src_code);
    assign dst_val  = read_code(dst_code);

    // Merged write port for loads, transfers and both halves of an exchange
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            cw_val[i] = '0;
        end
        cw_en = '0;
        if (ld) begin
            cw_en[ld_sel]  = 1'b1;
            cw_val[ld_sel] = ld_data;
        end
        if ((tfr || exg) && codes_ok) begin
            cw_en[dst_code]  = 1'b1;
            cw_val[dst_code] = src_val;
        end
        if (exg && codes_ok) begin
            cw_en[src_code]  = 1'b1;
            cw_val[src_code] = dst_val;
        end
    end

    always_comb begin
        case (acc_sel)
            ACC_A:   idx_racc = {{`KCPU_BYTE_W{a[`KCPU_BYTE_W-1]}}, a};
            ACC_B:   idx_racc = {{`KCPU_BYTE_W{b[`KCPU_BYTE_W-1]}}, b};
            default: idx_racc = d;
        endcase
    end

    // Byte offered to the stack RAM
    always_comb begin
        psh_byte = '0;
        if (cur_bit[MSK_CC])    psh_byte = cc;
        if (cur_bit[MSK_A])     psh_byte = a;
        if (cur_bit[MSK_B])     psh_byte = b;
        if (cur_bit[MSK_DP])    psh_byte = dp;
        if (cur_bit[MSK_X])     psh_byte = get_half(x, hihalf);
        if (cur_bit[MSK_Y])     psh_byte = get_half(y, hihalf);
        if (cur_bit[MSK_OTHER]) psh_byte = get_half(other_sp, hihalf);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            a  <= '0;
            b  <= '0;
            dp <= '0;
            cc <= '0;
            x  <= '0;
            y  <= '0;
            u  <= '0;
            s  <= '0;
        end else if (cen) begin
            if (cw_en[REG_A]) a <= cw_val[REG_A][`KCPU_BYTE_W-1:0];
            if (cw_en[REG_B]) b <= cw_val[REG_B][`KCPU_BYTE_W-1:0];
            if (cw_en[REG_X]) x <= cw_val[REG_X];
            if (cw_en[REG_Y]) y <= cw_val[REG_Y];
            if (cw_en[REG_S]) s <= cw_val[REG_S];
            if (cw_en[REG_U]) u <= cw_val[REG_U];
            if (ld_dp) dp <= ld_data[`KCPU_BYTE_W-1:0];

            if (idx_post || idx_pre) begin
                case (idx_sel)
                    IDX_X: x <= idx_move(x);
                    IDX_Y: y <= idx_move(y);
                    IDX_U: u <= idx_move(u);
                    IDX_S: s <= idx_move(s);
                endcase
            end

            // Active stack pointer
            if (sp_dec || sp_inc) begin
                if (use_u_q)
                    u <= sp_next;
                else
                    s <= sp_next;
            end

            // Pulled byte lands one cycle after its read
            if (pul_we) begin
                if (cur_bit[MSK_CC]) cc <= rdata;
                if (cur_bit[MSK_A])  a  <= rdata;
                if (cur_bit[MSK_B])  b  <= rdata;
                if (cur_bit[MSK_DP]) dp <= rdata;
                if (cur_bit[MSK_X])  x  <= set_half(x, hihalf, rdata);
                if (cur_bit[MSK_Y])  y  <= set_half(y, hihalf, rdata);
                if (cur_bit[MSK_OTHER]) begin
                    if (use_u_q)
                        s <= set_half(s, hihalf, rdata);
                    else
                        u <= set_half(u, hihalf, rdata);
                end
            end
        end
    end

    a_cur_bit_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(cur_bit));
    a_sp_move_excl: assert property (@(posedge clk) disable iff (rst) !(sp_dec && sp_inc));

endmodule

//--- hw/kcpu_stack_seq.sv
// Stack operations assume cen stays high until done; psh and pul while busy are dropped
`timescale 1ns/1ps
`include "kcpu_config.svh"

module kcpu_stack_seq
    import kcpu_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      cen,
    input  logic                      psh,
    input  logic                      pul,
    input  stack_mask_t               mask,
    input  logic                      use_u,
    input  word_t                     sp_addr,
    output stack_mask_t               cur_bit,
    output logic                      hihalf,
    output logic                      sp_dec,
    output logic                      sp_inc,
    output logic                      pul_we,
    output logic                      use_u_q,
    output logic [`KCPU_STACK_AW-1:0] ram_addr,
    output logic                      ram_we,
    output logic                      busy,
    output logic                      done
);

    seq_state_t  state;
    stack_mask_t mask_in;
    stack_mask_t mask_q;
    stack_mask_t mask_nx;
    stack_mask_t sel_bit;
    stack_mask_t wb_bit;
    logic        phase;
    logic        wide;
    logic        last_byte;
    logic        is_pull;
    logic        sel_hi;
    logic        wb_hi;
    word_t       sp_m1;

    assign mask_in = mask & ~(stack_mask_t'(1) << MSK_RSV);
    assign is_pull = (state == PULL_ADDR) || (state == PULL_LAST);

    // Push walks down from bit 6, pull walks up from bit 0
    always_comb begin
        sel_bit = '0;
        if (is_pull) begin
            sel_bit = mask_q & (~mask_q + stack_mask_t'(1));
        end else begin
            for (int i = 0; i < 8; i++) begin
                if (mask_q[i]) sel_bit = stack_mask_t'(1) << i;
            end
        end
    end

    // phase marks the second byte of a 16-bit entry
    assign wide      = sel_bit[MSK_X] | sel_bit[MSK_Y] | sel_bit[MSK_OTHER];
    assign last_byte = !wide || phase;
    assign mask_nx   = last_byte ? (mask_q & ~sel_bit) : mask_q;
    assign sel_hi    = is_pull ? (wide && !phase) : phase;

    assign cur_bit  = is_pull ? wb_bit : sel_bit;
    assign hihalf   = is_pull ? wb_hi : sel_hi;
    assign pul_we   = is_pull && wb_bit != '0;
    assign sp_dec   = (state == PUSH) && (mask_q != '0);
    assign sp_inc   = (state == PULL_ADDR) && (mask_q != '0);
    assign sp_m1    = sp_addr - word_t'(1);
    assign ram_addr = sp_dec ? sp_m1[`KCPU_STACK_AW-1:0] : sp_addr[`KCPU_STACK_AW-1:0];
    assign ram_we   = cen && sp_dec;
    assign busy     = (state == PUSH) || (state == PULL_ADDR) || (state == PULL_LAST);
    assign done     = (state == DONE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= IDLE;
            mask_q  <= '0;
            phase   <= 1'b0;
            use_u_q <= 1'b0;
            wb_bit  <= '0;
            wb_hi   <= 1'b0;
        end else if (cen) begin
            // Pull write-back trails the read by the RAM latency
            wb_bit <= sp_inc ? sel_bit : '0;
            wb_hi  <= sel_hi;
            case (state)
                IDLE, DONE: begin
                    state <= IDLE;
                    if (psh || pul) begin
                        mask_q  <= mask_in;
                        use_u_q <= use_u;
                        phase   <= 1'b0;
                        state   <= psh ? PUSH : PULL_ADDR;
                    end
                end
                PUSH: begin
                    mask_q <= mask_nx;
                    phase  <= !last_byte;
                    if (mask_nx == '0) state <= DONE;
                end
                PULL_ADDR: begin
                    mask_q <= mask_nx;
                    phase  <= !last_byte;
                    if (mask_q == '0)
                        state <= DONE;
                    else if (mask_nx == '0)
                        state <= PULL_LAST;
                end
                PULL_LAST: state <= DONE;
                default:   state <= IDLE;
            endcase
        end
    end

    a_done_not_busy: assert property (@(posedge clk) disable iff (rst) !(done && busy));

endmodule

//--- hw/kcpu_stack_ram.sv
// Contents are not reset; a read at the address being written returns the old byte
`timescale 1ns/1ps
`include "kcpu_config.svh"

module kcpu_stack_ram
    import kcpu_pkg::*;
(
    input  logic                      clk,
    input  logic [`KCPU_STACK_AW-1:0] addr,
    input  logic                      we,
    input  byte_t                     wdata,
    output byte_t                     rdata
);

    localparam int DEPTH = 1 << `KCPU_STACK_AW;

    byte_t mem [0:DEPTH-1];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    // Registered read, data one cycle after the address
    always_ff @(posedge clk) begin
        rdata <= mem[addr];
    end

endmodule

//--- hw/kcpu_regs_top.sv
// Commands are one-cycle strobes qualified by cen; wait for done after psh or pul
`timescale 1ns/1ps
`include "kcpu_config.svh"

module kcpu_regs_top
    import kcpu_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        cen,
    input  logic        ld,
    input  reg_code_t   ld_sel,
    input  logic        ld_dp,
    input  word_t       ld_data,
    input  logic        tfr,
    input  logic        exg,
    input  byte_t       postbyte,
    input  logic        psh,
    input  logic        pul,
    input  stack_mask_t mask,
    input  logic        use_u,
    input  logic        idx_post,
    input  logic        idx_pre,
    input  idx_sel_t    idx_sel,
    input  logic        idxw,
    input  acc_sel_t    acc_sel,
    output byte_t       a,
    output byte_t       b,
    output byte_t       dp,
    output byte_t       cc,
    output word_t       x,
    output word_t       y,
    output word_t       u,
    output word_t       s,
    output word_t       idx_racc,
    output logic        busy,
    output logic        done
);

    stack_mask_t               cur_bit;
    logic                      hihalf;
    logic                      sp_dec;
    logic                      sp_inc;
    logic                      pul_we;
    logic                      use_u_q;
    word_t                     sp_addr;
    byte_t                     psh_byte;
    byte_t                     rdata;
    logic [`KCPU_STACK_AW-1:0] ram_addr;
    logic                      ram_we;

    kcpu_regs u_regs (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .ld       (ld),
        .ld_sel   (ld_sel),
        .ld_dp    (ld_dp),
        .ld_data  (ld_data),
        .tfr      (tfr),
        .exg      (exg),
        .postbyte (postbyte),
        .idx_post (idx_post),
        .idx_pre  (idx_pre),
        .idx_sel  (idx_sel),
        .idxw     (idxw),
        .acc_sel  (acc_sel),
        .cur_bit  (cur_bit),
        .hihalf   (hihalf),
        .sp_dec   (sp_dec),
        .sp_inc   (sp_inc),
        .pul_we   (pul_we),
        .use_u_q  (use_u_q),
        .rdata    (rdata),
        .sp_addr  (sp_addr),
        .psh_byte (psh_byte),
        .idx_racc (idx_racc),
        .a        (a),
        .b        (b),
        .dp       (dp),
        .cc       (cc),
        .x        (x),
        .y        (y),
        .u        (u),
        .s        (s)
    );

    kcpu_stack_seq u_seq (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .psh      (psh),
        .pul      (pul),
        .mask     (mask),
        .use_u    (use_u),
        .sp_addr  (sp_addr),
        .cur_bit  (cur_bit),
        .hihalf   (hihalf),
        .sp_dec   (sp_dec),
        .sp_inc   (sp_inc),
        .pul_we   (pul_we),
        .use_u_q  (use_u_q),
        .ram_addr (ram_addr),
        .ram_we   (ram_we),
        .busy     (busy),
        .done     (done)
    );

    kcpu_stack_ram u_ram (
        .clk   (clk),
        .addr  (ram_addr),
        .we    (ram_we),
        .wdata (psh_byte),
        .rdata (rdata)
    );

endmodule

//--- verif/kcpu_regs_tb.sv
// Holds cen high for the whole run; push/pull checks rely on the stack RAM keeping its bytes between the two
`timescale 1ns/1ps

module kcpu_regs_tb
    import kcpu_pkg::*;
();

    logic        clk = 1'b0;
    logic        rst;
    logic        cen;
    logic        ld;
    reg_code_t   ld_sel;
    logic        ld_dp;
    word_t       ld_data;
    logic        tfr;
    logic        exg;
    byte_t       postbyte;
    logic        psh;
    logic        pul;
    stack_mask_t mask;
    logic        use_u;
    logic        idx_post;
    logic        idx_pre;
    idx_sel_t    idx_sel;
    logic        idxw;
    acc_sel_t    acc_sel;
    byte_t       a;
    byte_t       b;
    byte_t       dp;
    byte_t       cc;
    word_t       x;
    word_t       y;
    word_t       u;
    word_t       s;
    word_t       idx_racc;
    logic        busy;
    logic        done;

    logic [31:0] lfsr;

    // Model registers and the values saved before a push
    byte_t       m_a;
    byte_t       m_b;
    byte_t       m_dp;
    byte_t       m_cc;
    word_t       m_x;
    word_t       m_y;
    word_t       m_u;
    word_t       m_s;
    word_t       snap [0:6];

    kcpu_regs_top u_dut (.*);

    always #4 clk = ~clk;

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(logic [31:0] v);
        return {v[30:0], v[31] ^ v[21] ^ v[1] ^ v[0]};
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic word_t ref_read(reg_code_t c);
        case (c)
            REG_A:   return {8'h00, m_a};
            REG_B:   return {8'h00, m_b};
            REG_X:   return m_x;
            REG_Y:   return m_y;
            REG_S:   return m_s;
            REG_U:   return m_u;
            default: return '0;
        endcase
    endfunction

    task automatic ref_write(reg_code_t c, word_t v);
        case (c)
            REG_A:   m_a = v[7:0];
            REG_B:   m_b = v[7:0];
            REG_X:   m_x = v;
            REG_Y:   m_y = v;
            REG_S:   m_s = v;
            REG_U:   m_u = v;
            default: ;
        endcase
    endtask

    // Invalid source or destination leaves everything alone
    task automatic ref_xfer(logic xg, byte_t pb);
        reg_code_t src;
        reg_code_t dst;
        word_t     sv;
        word_t     dv;
        src = pb[6:4];
        dst = pb[2:0];
        if (src <= REG_U && dst <= REG_U) begin
            sv = ref_read(src);
            dv = ref_read(dst);
            ref_write(dst, sv);
            if (xg)
                ref_write(src, dv);
        end
    endtask

    function automatic word_t ref_step(word_t w, logic pre, logic wide);
        word_t st;
        st = wide ? word_t'(2) : word_t'(1);
        return pre ? w - st : w + st;
    endfunction

    task automatic ref_idx(idx_sel_t sel, logic pre, logic wide);
        case (sel)
            IDX_X: m_x = ref_step(m_x, pre, wide);
            IDX_Y: m_y = ref_step(m_y, pre, wide);
            IDX_U: m_u = ref_step(m_u, pre, wide);
            IDX_S: m_s = ref_step(m_s, pre, wide);
        endcase
    endtask

    function automatic word_t ref_racc(acc_sel_t sel);
        case (sel)
            ACC_A:   return {{8{m_a[7]}}, m_a};
            ACC_B:   return {{8{m_b[7]}}, m_b};
            default: return {m_a, m_b};
        endcase
    endfunction

    // Bits 4 to 6 are 16-bit entries, bit 7 counts for nothing
    function automatic int ref_bytes(stack_mask_t m);
        int n;
        n = 0;
        for (int i = 0; i < 7; i++) begin
            if (m[i])
                n += (i >= MSK_X) ? 2 : 1;
        end
        return n;
    endfunction

    task automatic take_snapshot(logic uu);
        snap[0] = {8'h00, m_cc};
        snap[1] = {8'h00, m_a};
        snap[2] = {8'h00, m_b};
        snap[3] = {8'h00, m_dp};
        snap[4] = m_x;
        snap[5] = m_y;
        snap[6] = uu ? m_s : m_u;
    endtask

    task automatic restore_masked(stack_mask_t m, logic uu);
        if (m[0]) m_cc = snap[0][7:0];
        if (m[1]) m_a = snap[1][7:0];
        if (m[2]) m_b = snap[2][7:0];
        if (m[3]) m_dp = snap[3][7:0];
        if (m[4]) m_x = snap[4];
        if (m[5]) m_y = snap[5];
        if (m[6]) begin
            if (uu)
                m_s = snap[6];
            else
                m_u = snap[6];
        end
    endtask

    task automatic move_sp(logic uu, logic down, int n);
        if (uu)
            m_u = down ? m_u - word_t'(n) : m_u + word_t'(n);
        else
            m_s = down ? m_s - word_t'(n) : m_s + word_t'(n);
    endtask

    task automatic stop_run(string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_byte(string name, byte_t exp, byte_t act);
        if (act !== exp)
            stop_run($sformatf("ERROR %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_word(string name, word_t exp, word_t act);
        if (act !== exp)
            stop_run($sformatf("ERROR %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_regs(string name);
        check_byte({name, " a"}, m_a, a);
        check_byte({name, " b"}, m_b, b);
        check_byte({name, " dp"}, m_dp, dp);
        check_byte({name, " cc"}, m_cc, cc);
        check_word({name, " x"}, m_x, x);
        check_word({name, " y"}, m_y, y);
        check_word({name, " u"}, m_u, u);
        check_word({name, " s"}, m_s, s);
    endtask

    task automatic check_racc(string name);
        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
            acc_sel <= acc_sel_t'(i);
            @(negedge clk);
            check_word($sformatf("%s acc_sel %0d", name, i), ref_racc(acc_sel_t'(i)), idx_racc);
        end
    endtask

    task automatic clear_strobes();
        ld       <= 1'b0;
        ld_dp    <= 1'b0;
        tfr      <= 1'b0;
        exg      <= 1'b0;
        psh      <= 1'b0;
        pul      <= 1'b0;
        idx_post <= 1'b0;
        idx_pre  <= 1'b0;
    endtask

    task automatic do_load(reg_code_t c, word_t v);
        @(posedge clk);
        ld      <= 1'b1;
        ld_sel  <= c;
        ld_data <= v;
        @(posedge clk);
        clear_strobes();
        @(negedge clk);
        ref_write(c, v);
    endtask

    task automatic do_load_dp(word_t v);
        @(posedge clk);
        ld_dp   <= 1'b1;
        ld_data <= v;
        @(posedge clk);
        clear_strobes();
        @(negedge clk);
        m_dp = v[7:0];
    endtask

    task automatic do_xfer(logic xg, byte_t pb);
        @(posedge clk);
        tfr      <= !xg;
        exg      <= xg;
        postbyte <= pb;
        @(posedge clk);
        clear_strobes();
        @(negedge clk);
        ref_xfer(xg, pb);
    endtask

    task automatic do_idx(idx_sel_t sel, logic pre, logic wide);
        @(posedge clk);
        idx_post <= !pre;
        idx_pre  <= pre;
        idx_sel  <= sel;
        idxw     <= wide;
        @(posedge clk);
        clear_strobes();
        @(negedge clk);
        ref_idx(sel, pre, wide);
    endtask

    task automatic wait_done(string name);
        int n;
        n = 0;
        @(negedge clk);
        while (done !== 1'b1) begin
            if (n == 200)
                stop_run($sformatf("Timeout in %s waiting for done, sequencer state %s",
                                   name, u_dut.u_seq.state.name()));
            n++;
            @(negedge clk);
        end
        if (busy !== 1'b0)
            stop_run($sformatf("busy was still high while done pulsed in %s", name));
    endtask

    task automatic stack_op(logic is_pul, stack_mask_t m, logic uu, string name);
        @(posedge clk);
        psh   <= !is_pul;
        pul   <= is_pul;
        mask  <= m;
        use_u <= uu;
        @(posedge clk);
        clear_strobes();
        wait_done(name);
    endtask

    // cc has no load port so the byte goes out of a onto the stack and back into cc
    task automatic load_cc(byte_t v, logic uu);
        do_load(REG_A, word_t'(v));
        stack_op(1'b0, stack_mask_t'(1) << MSK_A, uu, "cc load push");
        stack_op(1'b1, stack_mask_t'(1) << MSK_CC, uu, "cc load pull");
        m_cc = v;
    endtask

    task automatic load_random(reg_code_t keep);
        load_cc(byte_t'(rand_bits(8)), keep != REG_S);
        for (int i = 0; i < 6; i++) begin
            if (reg_code_t'(i) != keep)
                do_load(reg_code_t'(i), word_t'(rand_bits(16)));
        end
        do_load_dp(word_t'(rand_bits(16)));
    endtask

    task automatic test_loads(int rounds);
        repeat (rounds) begin
            for (int i = 0; i < 6; i++) begin
                do_load(reg_code_t'(i), word_t'(rand_bits(16)));
                check_regs("load");
            end
            do_load_dp(word_t'(rand_bits(16)));
            check_regs("load dp");
            check_racc("racc after load");
        end
    endtask

    task automatic test_xfer(int count);
        byte_t pb;
        logic  xg;
        repeat (count) begin
            pb = byte_t'(rand_bits(8));
            xg = 1'(rand_bits(1));
            do_xfer(xg, pb);
            check_regs(xg ? "exg" : "tfr");
        end
    endtask

    task automatic test_index();
        for (int i = 0; i < 4; i++) begin
            for (int w = 0; w < 2; w++) begin
                do_idx(idx_sel_t'(i), 1'b0, 1'(w));
                check_regs("post increment");
                do_idx(idx_sel_t'(i), 1'b1, 1'(w));
                check_regs("pre decrement");
            end
        end
        load_random(3'd7);
        check_racc("racc after index");
    endtask

    task automatic test_push_pull(logic uu);
        stack_mask_t m;
        int          n;
        load_random(3'd7);
        m = stack_mask_t'(rand_bits(8));
        n = ref_bytes(m);
        take_snapshot(uu);
        stack_op(1'b0, m, uu, "push");
        move_sp(uu, 1'b1, n);
        check_regs("push");
        // Scribble over everything but the active pointer
        load_random(uu ? REG_U : REG_S);
        stack_op(1'b1, m, uu, "pull");
        restore_masked(m, uu);
        move_sp(uu, 1'b0, n);
        check_regs("pull");
    endtask

    task automatic test_busy_drop(logic uu);
        stack_mask_t m1;
        int          n;
        load_random(3'd7);
        m1 = stack_mask_t'(rand_bits(8)) | stack_mask_t'(8'h02);
        n  = ref_bytes(m1);
        take_snapshot(uu);
        @(posedge clk);
        psh   <= 1'b1;
        mask  <= m1;
        use_u <= uu;
        @(posedge clk);
        mask  <= ~m1;
        use_u <= !uu;
        @(negedge clk);
        if (busy !== 1'b1)
            stop_run("busy did not rise one cycle after the push strobe");
        @(posedge clk);
        clear_strobes();
        wait_done("push while busy");
        move_sp(uu, 1'b1, n);
        check_regs("push while busy");
        stack_op(1'b1, m1, uu, "pull after dropped push");
        restore_masked(m1, uu);
        move_sp(uu, 1'b0, n);
        check_regs("pull after dropped push");
    endtask

    initial begin
        rst      <= 1'b1;
        cen      <= 1'b1;
        ld_sel   <= REG_A;
        ld_data  <= '0;
        postbyte <= '0;
        mask     <= '0;
        use_u    <= 1'b0;
        idx_sel  <= IDX_X;
        idxw     <= 1'b0;
        acc_sel  <= ACC_A;
        clear_strobes();
        lfsr = 32'h0879_9c9e;
        m_a  = '0;
        m_b  = '0;
        m_dp = '0;
        m_cc = '0;
        m_x  = '0;
        m_y  = '0;
        m_u  = '0;
        m_s  = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_regs("reset");
        if (busy !== 1'b0 || done !== 1'b0)
            stop_run("busy or done was not low after reset");
        test_loads(4);
        test_xfer(60);
        test_index();
        for (int k = 0; k < 6; k++) begin
            test_push_pull(1'b0);
            test_push_pull(1'b1);
        end
        test_busy_drop(1'b0);
        test_busy_drop(1'b1);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+hw
hw/kcpu_pkg.sv
hw/kcpu_regs.sv
hw/kcpu_stack_seq.sv
hw/kcpu_stack_ram.sv
hw/kcpu_regs_top.sv
verif/kcpu_regs_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := kcpu_regs_tb
FILELIST   := vlog.f
OBJDIR     := obj_dir
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
